// ==== design/rvv_isa_pkg.sv ====
`default_nettype none

package rvv_isa_pkg;

	// major opcodes used by the vector extension
	localparam logic [6:0] OPC_OP_V     = 7'b1010111;
	localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
	localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

	localparam logic [2:0] F3_CFG    = 3'b111; // vsetvli / vsetivli / vsetvl
	localparam logic [2:0] WIDTH_E32 = 3'b110; // 32-bit element memory access

	// one instruction word, two decodings
	typedef union packed {
		// vset* layout
		struct packed {
			logic [1:0] sel;    // 0x vsetvli, 11 vsetivli, 10 vsetvl
			logic [9:0] zimm;   // vtype immediate
			logic [4:0] rs1;    // uimm for vsetivli
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} cfg;
		// vector load / store layout
		struct packed {
			logic [2:0] nf;
			logic       mew;
			logic [1:0] mop;
			logic       vm;
			logic [4:0] lumop;
			logic [4:0] rs1;
			logic [2:0] width;
			logic [4:0] vd;     // vs3 for stores
			logic [6:0] opcode;
		} mem;
	} rvv_insn_u;

endpackage

`default_nettype wire

// ==== design/rvv_arch_pkg.sv ====
`default_nettype none

package rvv_arch_pkg;

	// vector register file
	localparam int NUM_VREGS = 32;
	localparam int VREG_AW   = 5;

	// vtype layout
	localparam int          VILL_BIT      = 31;
	localparam logic [31:0] VTYPE_ILLEGAL = 32'h1 << VILL_BIT;

	// vsew codes 0..2 are e8, e16, e32
	localparam logic [2:0] SEW_MAX_CODE = 3'd2;

	// vlmul code with no meaning
	localparam logic [2:0] LMUL_RESERVED = 3'd4;

endpackage

`default_nettype wire

// ==== design/rvv_insn_decode.sv ====
`default_nettype none

module rvv_insn_decode
	import rvv_isa_pkg::*;
(
	input  rvv_insn_u insn_i,
	output logic      is_cfg_o,
	output logic      is_load_o,
	output logic      is_store_o,
	output logic      is_rvv_o
);

	logic cfg_sel_ok;
	logic mem_fmt_ok;

	// vsetvl needs funct7 = 1000000, the other two forms take any zimm
	assign cfg_sel_ok = !insn_i.cfg.sel[1] || insn_i.cfg.sel[0] ||
		(insn_i.cfg.zimm[9:5] == 5'd0);

	assign is_cfg_o = (insn_i.cfg.opcode == OPC_OP_V) &&
		(insn_i.cfg.funct3 == F3_CFG) && cfg_sel_ok;

	// only unmasked unit-stride e32 accesses
	assign mem_fmt_ok = (insn_i.mem.nf == 3'd0) &&
		!insn_i.mem.mew &&
		(insn_i.mem.mop == 2'd0) &&
		insn_i.mem.vm &&
		(insn_i.mem.lumop == 5'd0) &&
		(insn_i.mem.width == WIDTH_E32);

	assign is_load_o  = mem_fmt_ok && (insn_i.mem.opcode == OPC_LOAD_FP);
	assign is_store_o = mem_fmt_ok && (insn_i.mem.opcode == OPC_STORE_FP);

	assign is_rvv_o = is_cfg_o || is_load_o || is_store_o;

endmodule

`default_nettype wire

// ==== design/rvv_vcfg_unit.sv ====
`default_nettype none

module rvv_vcfg_unit
	import rvv_isa_pkg::*;
	import rvv_arch_pkg::*;
#(
	parameter int VLEN = 128
) (
	input  logic        clk,
	input  logic        resetn,
	input  logic        start_i,
	input  rvv_insn_u   insn_i,
	input  logic [31:0] rs1_i,
	input  logic [31:0] rs2_i,
	output logic        done_o,
	output logic [31:0] vl_o
);

	logic [31:0] vtype_q;
	logic [31:0] vl_q;
	logic        done_q;

	logic        is_vsetivli;
	logic        is_vsetvl;
	logic [31:0] new_vtype;
	logic [2:0]  vsew;
	logic [2:0]  vlmul;
	logic [31:0] elems_per_reg;
	logic [31:0] vlmax;
	logic [31:0] avl;

	assign is_vsetivli = (insn_i.cfg.sel == 2'b11);
	assign is_vsetvl   = (insn_i.cfg.sel == 2'b10);

	always_comb begin
		new_vtype = is_vsetvl ? rs2_i : {24'd0, insn_i.cfg.zimm[7:0]};
		vsew  = new_vtype[5:3];
		vlmul = new_vtype[2:0];
		elems_per_reg = 32'(VLEN) >> (32'(vsew) + 32'd3);

		if (vsew > SEW_MAX_CODE || vlmul == LMUL_RESERVED)
			vlmax = 32'd0;
		else if (!vlmul[2])
			vlmax = elems_per_reg << vlmul[1:0];
		else
			vlmax = elems_per_reg >> (3'd4 - {1'b0, vlmul[1:0]}); // fractional lmul

		// avl selection
		if (is_vsetivli)
			avl = {27'd0, insn_i.cfg.rs1};
		else if (insn_i.cfg.rs1 != 5'd0)
			avl = rs1_i;
		else if (insn_i.cfg.rd != 5'd0)
			avl = 32'hffff_ffff; // rd only, ask for vlmax
		else
			avl = vl_q;          // x0/x0 keeps vl
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_q <= VTYPE_ILLEGAL;
			vl_q    <= 32'd0;
			done_q  <= 1'b0;
		end else begin
			done_q <= start_i;
			if (start_i) begin
				if (vlmax == 32'd0) begin
					vtype_q <= VTYPE_ILLEGAL;
					vl_q    <= 32'd0;
				end else begin
					vtype_q <= new_vtype;
					vl_q    <= (avl <= vlmax) ? avl : vlmax;
				end
			end
		end
	end

	assign done_o = done_q;
	assign vl_o   = vl_q;

	// largest vlmax is e8 with lmul 8
	a_vl_bound: assert property (@(posedge clk) disable iff (!resetn)
		vl_q <= 32'(VLEN / 8 * 8));

	a_vill_zero_vl: assert property (@(posedge clk) disable iff (!resetn)
		vtype_q[VILL_BIT] |-> (vl_q == 32'd0));

endmodule

`default_nettype wire

// ==== design/rvv_vmem_unit.sv ====
`default_nettype none

module rvv_vmem_unit
	import rvv_arch_pkg::*;
#(
	parameter int VLEN = 128
) (
	input  logic                         clk,
	input  logic                         resetn,
	input  logic                         start_i,
	input  logic                         is_store_i,
	input  logic [VREG_AW-1:0]           vd_i,
	input  logic [31:0]                  base_i,
	input  logic [31:0]                  vl_i,
	input  logic [31:0]                  mem_rdata_i,
	input  logic                         mem_done_i,
	output logic                         mem_wen_o,
	output logic                         mem_op_o,
	output logic [31:0]                  mem_addr_o,
	output logic [31:0]                  mem_wdata_o,
	output logic                         vreg_we_o,
	output logic [VREG_AW-1:0]           vreg_addr_o,
	output logic [$clog2(VLEN/32)-1:0]   vreg_word_o,
	output logic [31:0]                  vreg_wdata_o,
	input  logic [31:0]                  vreg_rdata_i,
	output logic                         done_o
);

	localparam int WORD_W = $clog2(VLEN / 32);

	localparam logic S_IDLE = 1'b0;
	localparam logic S_WAIT = 1'b1; // one word outstanding

	logic        state_q;
	logic [31:0] elem_q;  // element in flight
	logic        wen_q;
	logic        op_q;
	logic        done_q;
	logic        last_elem;
	logic        word_done;

	assign last_elem = (elem_q == vl_i - 32'd1);
	assign word_done = (state_q == S_WAIT) && mem_done_i;

	// element i sits in word i mod (VLEN/32) of register vd + i div (VLEN/32)
	assign vreg_word_o = elem_q[WORD_W-1:0];
	assign vreg_addr_o = vd_i + elem_q[WORD_W +: VREG_AW];

	assign mem_addr_o  = base_i + {elem_q[29:0], 2'b00};
	assign mem_wdata_o = vreg_rdata_i; // store data straight from the register file

	// load data lands in the register file at the done edge
	assign vreg_we_o    = word_done && !is_store_i;
	assign vreg_wdata_o = mem_rdata_i;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= S_IDLE;
			elem_q  <= 32'd0;
			wen_q   <= 1'b0;
			op_q    <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			wen_q  <= 1'b0;
			done_q <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (start_i) begin
						elem_q <= 32'd0;
						if (vl_i == 32'd0) begin
							done_q <= 1'b1; // nothing to move
						end else begin
							state_q <= S_WAIT;
							wen_q   <= 1'b1;
							op_q    <= 1'b1;
						end
					end
				end
				S_WAIT: begin
					if (mem_done_i) begin
						if (last_elem) begin
							state_q <= S_IDLE;
							op_q    <= 1'b0;
							done_q  <= 1'b1;
						end else begin
							elem_q <= elem_q + 32'd1;
							wen_q  <= 1'b1; // next word right away
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	assign mem_wen_o = wen_q;
	assign mem_op_o  = op_q;
	assign done_o    = done_q;

	// no new request while a word is still open
	a_no_wen_open: assert property (@(posedge clk) disable iff (!resetn)
		mem_op_o && !mem_done_i |=> !mem_wen_o);

	a_op_idle: assert property (@(posedge clk) disable iff (!resetn)
		(state_q == S_IDLE) |-> !mem_op_o);

endmodule

`default_nettype wire

// ==== design/rvv_vregs.sv ====
`default_nettype none

module rvv_vregs
	import rvv_arch_pkg::*;
#(
	parameter int VLEN = 128
) (
	input  logic                       clk,
	input  logic                       we_i,
	input  logic [VREG_AW-1:0]         addr_i,
	input  logic [$clog2(VLEN/32)-1:0] word_i,
	input  logic [31:0]                wdata_i,
	output logic [31:0]                rdata_o
);

	logic [VLEN-1:0] regs_q [NUM_VREGS];

	// word-granular write
	always_ff @(posedge clk) begin
		if (we_i)
			regs_q[addr_i][32*word_i +: 32] <= wdata_i;
	end

	assign rdata_o = regs_q[addr_i][32*word_i +: 32]; // async read

endmodule

`default_nettype wire

// ==== design/rvv_pcpi_resp.sv ====
`default_nettype none

module rvv_pcpi_resp (
	input  logic        clk,
	input  logic        resetn,
	input  logic        valid_i,
	input  logic        is_cfg_i,
	input  logic        is_load_i,
	input  logic        is_store_i,
	input  logic        cfg_done_i,
	input  logic        mem_done_i,
	input  logic [31:0] vl_i,
	output logic        cfg_start_o,
	output logic        mem_start_o,
	output logic        mem_load_o,
	output logic        mem_store_o,
	output logic        pcpi_wait_o,
	output logic        pcpi_ready_o,
	output logic        pcpi_wr_o,
	output logic [31:0] pcpi_rd_o
);

	logic active_q;
	logic accept;
	logic unit_done;

	// hold off while the core still sees the previous ready
	assign accept = valid_i && (is_cfg_i || is_load_i || is_store_i) &&
		!active_q && !pcpi_ready_o;
	assign unit_done = cfg_done_i || mem_done_i;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active_q     <= 1'b0;
			cfg_start_o  <= 1'b0;
			mem_start_o  <= 1'b0;
			mem_load_o   <= 1'b0;
			mem_store_o  <= 1'b0;
			pcpi_wait_o  <= 1'b0;
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o    <= 1'b0;
		end else begin
			cfg_start_o  <= 1'b0;
			mem_start_o  <= 1'b0;
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o    <= 1'b0;
			if (accept) begin
				active_q    <= 1'b1;
				pcpi_wait_o <= 1'b1;
				cfg_start_o <= is_cfg_i;
				mem_start_o <= !is_cfg_i;
				mem_load_o  <= is_load_i;
				mem_store_o <= is_store_i;
			end
			if (unit_done) begin
				active_q     <= 1'b0;
				pcpi_wait_o  <= 1'b0;
				pcpi_ready_o <= 1'b1;
				pcpi_wr_o    <= cfg_done_i; // only vset* writes rd
				mem_load_o   <= 1'b0;
				mem_store_o  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_done_i)
			pcpi_rd_o <= vl_i;
	end

	a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		pcpi_ready_o |=> !pcpi_ready_o);

endmodule

`default_nettype wire

// ==== design/rvv_coproc.sv ====
`default_nettype none

module rvv_coproc
	import rvv_isa_pkg::*;
	import rvv_arch_pkg::*;
#(
	parameter int VLEN = 128
) (
	input  logic        clk,
	input  logic        resetn,
	input  logic        pcpi_valid_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  logic [31:0] pcpi_rs2_i,
	output logic        pcpi_wr_o,
	output logic        pcpi_wait_o,
	output logic        pcpi_ready_o,
	output logic [31:0] pcpi_rd_o,
	output logic        pcpi_is_rvv_o,
	input  logic [31:0] mem_rdata_i,
	input  logic        mem_done_i,
	output logic        mem_op_o,
	output logic        mem_load_o,
	output logic        mem_store_o,
	output logic        mem_wen_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o
);

	localparam int WORD_W = $clog2(VLEN / 32);

	rvv_insn_u          insn;
	logic               is_cfg, is_load, is_store;
	logic               cfg_start, mem_start;
	logic               cfg_done, mem_unit_done;
	logic [31:0]        vl;
	logic               vreg_we;
	logic [VREG_AW-1:0] vreg_addr;
	logic [WORD_W-1:0]  vreg_word;
	logic [31:0]        vreg_wdata, vreg_rdata;

	assign insn = pcpi_insn_i;

	rvv_insn_decode u_decode (
		.insn_i     (insn),
		.is_cfg_o   (is_cfg),
		.is_load_o  (is_load),
		.is_store_o (is_store),
		.is_rvv_o   (pcpi_is_rvv_o)
	);

	rvv_vcfg_unit #(.VLEN(VLEN)) u_vcfg (
		.clk     (clk),
		.resetn  (resetn),
		.start_i (cfg_start),
		.insn_i  (insn),
		.rs1_i   (pcpi_rs1_i),
		.rs2_i   (pcpi_rs2_i),
		.done_o  (cfg_done),
		.vl_o    (vl)
	);

	rvv_vmem_unit #(.VLEN(VLEN)) u_vmem (
		.clk          (clk),
		.resetn       (resetn),
		.start_i      (mem_start),
		.is_store_i   (mem_store_o),
		.vd_i         (insn.mem.vd),
		.base_i       (pcpi_rs1_i),
		.vl_i         (vl),
		.mem_rdata_i  (mem_rdata_i),
		.mem_done_i   (mem_done_i),
		.mem_wen_o    (mem_wen_o),
		.mem_op_o     (mem_op_o),
		.mem_addr_o   (mem_addr_o),
		.mem_wdata_o  (mem_wdata_o),
		.vreg_we_o    (vreg_we),
		.vreg_addr_o  (vreg_addr),
		.vreg_word_o  (vreg_word),
		.vreg_wdata_o (vreg_wdata),
		.vreg_rdata_i (vreg_rdata),
		.done_o       (mem_unit_done)
	);

	rvv_vregs #(.VLEN(VLEN)) u_vregs (
		.clk     (clk),
		.we_i    (vreg_we),
		.addr_i  (vreg_addr),
		.word_i  (vreg_word),
		.wdata_i (vreg_wdata),
		.rdata_o (vreg_rdata)
	);

	rvv_pcpi_resp u_resp (
		.clk          (clk),
		.resetn       (resetn),
		.valid_i      (pcpi_valid_i),
		.is_cfg_i     (is_cfg),
		.is_load_i    (is_load),
		.is_store_i   (is_store),
		.cfg_done_i   (cfg_done),
		.mem_done_i   (mem_unit_done),
		.vl_i         (vl),
		.cfg_start_o  (cfg_start),
		.mem_start_o  (mem_start),
		.mem_load_o   (mem_load_o),
		.mem_store_o  (mem_store_o),
		.pcpi_wait_o  (pcpi_wait_o),
		.pcpi_ready_o (pcpi_ready_o),
		.pcpi_wr_o    (pcpi_wr_o),
		.pcpi_rd_o    (pcpi_rd_o)
	);

endmodule

`default_nettype wire

// ==== verif/tb_rvv_coproc.sv ====
`default_nettype none

module tb_rvv_coproc
	import rvv_isa_pkg::*;
	import rvv_arch_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int VLEN           = 128;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int MEM_WORDS      = 1024;

	logic        clk;
	logic        resetn;
	logic        pcpi_valid_i;
	logic [31:0] pcpi_insn_i;
	logic [31:0] pcpi_rs1_i;
	logic [31:0] pcpi_rs2_i;
	logic        pcpi_wr_o;
	logic        pcpi_wait_o;
	logic        pcpi_ready_o;
	logic [31:0] pcpi_rd_o;
	logic        pcpi_is_rvv_o;
	logic [31:0] mem_rdata_i;
	logic        mem_done_i;
	logic        mem_op_o;
	logic        mem_load_o;
	logic        mem_store_o;
	logic        mem_wen_o;
	logic [31:0] mem_addr_o;
	logic [31:0] mem_wdata_o;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] mem_words [MEM_WORDS];
	logic [31:0] addr_log [$];          // one entry per mem_wen_o pulse
	int          op_low_count = 0;
	int          load_wen_count = 0;
	int          store_wen_count = 0;
	time         last_done_time = 0;
	logic        resp_wr;               // response captured with pcpi_ready_o
	logic        resp_wait;
	logic [31:0] resp_rd;
	logic        resp_is_rvv;
	logic        resp_wait_held;        // pcpi_wait_o high in every cycle before ready
	time         ready_time;
	logic [31:0] model_vl;              // vl as the testbench expects it

	rvv_coproc #(.VLEN(VLEN)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// initial memory contents, a function of the full byte address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0000;
	endfunction

	function automatic logic [31:0] calc_vlmax(input logic [2:0] sew, input logic [2:0] lmul);
		logic [31:0] per_reg;
		per_reg = 32'(VLEN) / (32'd8 << sew);
		if (sew > SEW_MAX_CODE || lmul == LMUL_RESERVED)
			return 32'd0;
		case (lmul)
			3'd5: return per_reg / 32'd8;
			3'd6: return per_reg / 32'd4;
			3'd7: return per_reg / 32'd2;
			default: return per_reg * (32'd1 << lmul);
		endcase
	endfunction

	function automatic logic [31:0] expected_vl(input logic [2:0] sew, input logic [2:0] lmul,
		input logic [31:0] avl);
		logic [31:0] vlmax;
		vlmax = calc_vlmax(sew, lmul);
		if (vlmax == 32'd0)
			return 32'd0;
		return (avl < vlmax) ? avl : vlmax;
	endfunction

	// vsetvli, or vsetivli when imm is set (rs1 then holds uimm)
	function automatic logic [31:0] enc_vset(input logic imm, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [2:0] sew, input logic [2:0] lmul);
		return {(imm ? 2'b11 : 2'b00), 4'b0000, sew, lmul, rs1, F3_CFG, rd, OPC_OP_V};
	endfunction

	function automatic logic [31:0] enc_vsetvl(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		return {2'b10, 5'd0, rs2, rs1, F3_CFG, rd, OPC_OP_V};
	endfunction

	// vle32.v / vse32.v, unmasked
	function automatic logic [31:0] enc_vmem(input logic store, input logic [4:0] vd,
		input logic [4:0] rs1);
		return {3'b000, 1'b0, 2'b00, 1'b1, 5'd0, rs1, WIDTH_E32, vd,
			(store ? OPC_STORE_FP : OPC_LOAD_FP)};
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// memory model, one word outstanding, 0..3 idle cycles before mem_done_i
	initial begin : mem_model
		logic [31:0] rng_state;
		logic [31:0] addr_q;
		logic [1:0]  idle;
		int          i;
		mem_done_i  = 1'b0;
		mem_rdata_i = 32'd0;
		rng_state   = 32'haf10;
		for (i = 0; i < MEM_WORDS; i++)
			mem_words[i] = fill_word(32'(i) << 2);
		forever begin
			@(negedge clk);
			mem_done_i = 1'b0;
			if (mem_wen_o) begin
				addr_q = mem_addr_o;
				addr_log.push_back(addr_q);
				if (!mem_op_o)
					op_low_count++;
				if (mem_load_o)
					load_wen_count++;
				if (mem_store_o) begin
					store_wen_count++;
					mem_words[addr_q[11:2]] = mem_wdata_o;
				end
				rng_state = xorshift(rng_state);
				idle = rng_state[1:0];
				repeat (idle) @(negedge clk);
				mem_rdata_i    = mem_words[addr_q[11:2]];
				mem_done_i     = 1'b1;
				last_done_time = $time;
			end
		end
	end

	task automatic clear_log();
		addr_log.delete();
		op_low_count    = 0;
		load_wen_count  = 0;
		store_wen_count = 0;
	endtask

	// called at a falling edge, returns at a falling edge one cycle after ready
	task automatic issue_insn(input logic [31:0] insn, input logic [31:0] rs1,
		input logic [31:0] rs2, input logic expect_ready, output logic got_ready,
		output int latency);
		int cycles;
		pcpi_insn_i    = insn;
		pcpi_rs1_i     = rs1;
		pcpi_rs2_i     = rs2;
		pcpi_valid_i   = 1'b1;
		got_ready      = 1'b0;
		resp_wait_held = 1'b1;
		cycles         = 0;
		while (!got_ready && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			@(negedge clk);
			cycles++;
			got_ready = pcpi_ready_o;
			if (!got_ready && !pcpi_wait_o)
				resp_wait_held = 1'b0;
		end
		latency     = cycles - 1; // edges after the accepting edge
		resp_wr     = pcpi_wr_o;
		resp_wait   = pcpi_wait_o;
		resp_rd     = pcpi_rd_o;
		resp_is_rvv = pcpi_is_rvv_o;
		ready_time  = $time;
		pcpi_valid_i = 1'b0;
		if (!got_ready && expect_ready) begin
			errors++;
			$display("ERROR at %0t ns: no pcpi_ready_o within %0d cycles for instruction %h",
				$time, TIMEOUT_CYCLES, insn);
		end
		@(posedge clk);
		@(negedge clk);
		check_flag("pcpi_ready_o one cycle later", 1'b0, pcpi_ready_o);
	endtask

	task automatic run_vset(input string name, input logic [31:0] insn, input logic [31:0] rs1,
		input logic [31:0] rs2, input logic [31:0] exp_vl);
		logic got;
		int   lat;
		issue_insn(insn, rs1, rs2, 1'b1, got, lat);
		if (got) begin
			check_word({name, " latency"}, 32'd2, 32'(lat));
			check_flag({name, " pcpi_is_rvv_o"}, 1'b1, resp_is_rvv);
			check_flag({name, " pcpi_wait_o while busy"}, 1'b1, resp_wait_held);
			check_flag({name, " pcpi_wr_o"}, 1'b1, resp_wr);
			check_flag({name, " pcpi_wait_o"}, 1'b0, resp_wait);
			check_word({name, " pcpi_rd_o"}, exp_vl, resp_rd);
		end
		model_vl = exp_vl;
	endtask

	// checks the mem_wen_o log of one access of model_vl words at base
	task automatic check_access(input string name, input logic [31:0] base, input logic store);
		int i;
		check_word({name, " mem_wen_o count"}, model_vl, 32'(addr_log.size()));
		for (i = 0; i < addr_log.size(); i++)
			check_word({name, " mem_addr_o"}, base + (32'(i) << 2), addr_log[i]);
		check_word({name, " wen with mem_op_o low"}, 32'd0, 32'(op_low_count));
		check_word({name, " wen with mem_load_o"}, store ? 32'd0 : model_vl,
			32'(load_wen_count));
		check_word({name, " wen with mem_store_o"}, store ? model_vl : 32'd0,
			32'(store_wen_count));
		check_flag({name, " pcpi_is_rvv_o"}, 1'b1, resp_is_rvv);
		check_flag({name, " pcpi_wait_o while busy"}, 1'b1, resp_wait_held);
		check_flag({name, " pcpi_wr_o"}, 1'b0, resp_wr);
		check_flag({name, " mem_op_o after ready"}, 1'b0, mem_op_o);
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("test %-14s finished, %0d errors", name, errors - errs_before);
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		check_flag("pcpi_ready_o", 1'b0, pcpi_ready_o);
		check_flag("pcpi_wr_o", 1'b0, pcpi_wr_o);
		check_flag("pcpi_wait_o", 1'b0, pcpi_wait_o);
		check_flag("mem_wen_o", 1'b0, mem_wen_o);
		check_flag("mem_op_o", 1'b0, mem_op_o);
		check_flag("mem_load_o", 1'b0, mem_load_o);
		check_flag("mem_store_o", 1'b0, mem_store_o);
		// x0/x0 keeps vl, which is zero out of reset
		run_vset("x0/x0 after reset", enc_vset(1'b0, 5'd0, 5'd0, 3'd2, 3'd0), 32'd0, 32'd0,
			expected_vl(3'd2, 3'd0, model_vl));
		report_test("reset", e0);
	endtask

	task automatic test_vset_legal();
		int e0;
		e0 = errors;
		run_vset("vsetvli e32 m1", enc_vset(1'b0, 5'd1, 5'd2, 3'd2, 3'd0), 32'd5, 32'd0,
			expected_vl(3'd2, 3'd0, 32'd5));
		run_vset("vsetvli e8 m2", enc_vset(1'b0, 5'd1, 5'd2, 3'd0, 3'd1), 32'd20, 32'd0,
			expected_vl(3'd0, 3'd1, 32'd20));
		run_vset("vsetvli e16 mf2", enc_vset(1'b0, 5'd3, 5'd4, 3'd1, 3'd7), 32'd100, 32'd0,
			expected_vl(3'd1, 3'd7, 32'd100));
		run_vset("vsetvli e32 m8", enc_vset(1'b0, 5'd1, 5'd2, 3'd2, 3'd3), 32'd1000, 32'd0,
			expected_vl(3'd2, 3'd3, 32'd1000));
		// rs1 register value must be ignored by vsetivli
		run_vset("vsetivli e32 m4", enc_vset(1'b1, 5'd1, 5'd10, 3'd2, 3'd2), 32'hdead_beef,
			32'd0, expected_vl(3'd2, 3'd2, 32'd10));
		run_vset("vsetivli e8 mf8", enc_vset(1'b1, 5'd1, 5'd31, 3'd0, 3'd5), 32'd0, 32'd0,
			expected_vl(3'd0, 3'd5, 32'd31));
		report_test("vset_legal", e0);
	endtask

	task automatic test_vset_illegal();
		int e0;
		e0 = errors;
		run_vset("vsetivli e32 m1", enc_vset(1'b1, 5'd1, 5'd3, 3'd2, 3'd0), 32'd0, 32'd0,
			expected_vl(3'd2, 3'd0, 32'd3));
		run_vset("vsetvl lmul 4", enc_vsetvl(5'd1, 5'd2, 5'd3), 32'd8,
			{26'd0, 3'd2, LMUL_RESERVED}, expected_vl(3'd2, LMUL_RESERVED, 32'd8));
		run_vset("vsetivli e32 m1", enc_vset(1'b1, 5'd1, 5'd3, 3'd2, 3'd0), 32'd0, 32'd0,
			expected_vl(3'd2, 3'd0, 32'd3));
		run_vset("vsetvl sew 3", enc_vsetvl(5'd1, 5'd2, 5'd3), 32'd8, {26'd0, 3'd3, 3'd0},
			expected_vl(3'd3, 3'd0, 32'd8));
		run_vset("vsetvli rd only", enc_vset(1'b0, 5'd5, 5'd0, 3'd1, 3'd1), 32'd7, 32'd0,
			expected_vl(3'd1, 3'd1, 32'hffff_ffff));
		run_vset("vsetvli x0/x0", enc_vset(1'b0, 5'd0, 5'd0, 3'd1, 3'd2), 32'd0, 32'd0,
			expected_vl(3'd1, 3'd2, model_vl));
		report_test("vset_illegal", e0);
	endtask

	task automatic test_load_seq();
		int   e0;
		logic got;
		int   lat;
		e0 = errors;
		run_vset("setup e32 m4", enc_vset(1'b1, 5'd1, 5'd10, 3'd2, 3'd2), 32'd0, 32'd0,
			expected_vl(3'd2, 3'd2, 32'd10));
		clear_log();
		issue_insn(enc_vmem(1'b0, 5'd8, 5'd10), 32'h100, 32'd0, 1'b1, got, lat);
		check_access("load", 32'h100, 1'b0);
		check_word("load ready after last mem_done_i (cycles)", 32'd2,
			32'((ready_time - last_done_time) / 4));
		report_test("load_seq", e0);
	endtask

	task automatic test_round_trip();
		int          e0;
		int          i;
		logic        got;
		int          lat;
		logic [31:0] addr;
		e0 = errors;
		clear_log();
		issue_insn(enc_vmem(1'b1, 5'd8, 5'd11), 32'h400, 32'd0, 1'b1, got, lat);
		check_access("store", 32'h400, 1'b1);
		for (i = 0; i < int'(model_vl); i++) begin
			addr = 32'h400 + (32'(i) << 2);
			check_word("stored word", fill_word(32'h100 + (32'(i) << 2)), mem_words[addr[11:2]]);
		end
		addr = 32'h400 + (model_vl << 2); // first word past the vector stays untouched
		check_word("word past store", fill_word(addr), mem_words[addr[11:2]]);
		report_test("round_trip", e0);
	endtask

	task automatic test_zero_and_scalar();
		int   e0;
		logic got;
		int   lat;
		e0 = errors;
		run_vset("vsetvl illegal", enc_vsetvl(5'd1, 5'd2, 5'd3), 32'd8,
			{26'd0, 3'd2, LMUL_RESERVED}, expected_vl(3'd2, LMUL_RESERVED, 32'd8));
		clear_log();
		issue_insn(enc_vmem(1'b0, 5'd0, 5'd12), 32'h200, 32'd0, 1'b1, got, lat);
		check_flag("zero-length load pcpi_ready_o", 1'b1, got);
		check_word("zero-length load latency", 32'd2, 32'(lat));
		check_flag("zero-length load pcpi_is_rvv_o", 1'b1, resp_is_rvv);
		check_flag("zero-length load pcpi_wait_o while busy", 1'b1, resp_wait_held);
		check_word("zero-length load mem_wen_o count", 32'd0, 32'(addr_log.size()));
		// add x3, x1, x2
		pcpi_insn_i = {7'd0, 5'd2, 5'd1, 3'd0, 5'd3, 7'b0110011};
		@(posedge clk);
		check_flag("add pcpi_is_rvv_o", 1'b0, pcpi_is_rvv_o);
		@(negedge clk);
		issue_insn(pcpi_insn_i, 32'd1, 32'd2, 1'b0, got, lat);
		check_flag("add pcpi_ready_o", 1'b0, got);
		check_flag("add pcpi_wait_o", 1'b0, resp_wait);
		check_word("add mem_wen_o count", 32'd0, 32'(addr_log.size()));
		report_test("zero_scalar", e0);
	endtask

	initial begin
		resetn       = 1'b0;
		pcpi_valid_i = 1'b0;
		pcpi_insn_i  = 32'd0;
		pcpi_rs1_i   = 32'd0;
		pcpi_rs2_i   = 32'd0;
		model_vl     = 32'd0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		test_reset();
		test_vset_legal();
		test_vset_illegal();
		test_load_seq();
		test_round_trip();
		test_zero_and_scalar();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rvv_coproc.f ====
design/rvv_isa_pkg.sv
design/rvv_arch_pkg.sv
design/rvv_insn_decode.sv
design/rvv_vcfg_unit.sv
design/rvv_vmem_unit.sv
design/rvv_vregs.sv
design/rvv_pcpi_resp.sv
design/rvv_coproc.sv
verif/tb_rvv_coproc.sv

// ==== Makefile ====
SIM      = verilator
VFLAGS   = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = tb_rvv_coproc
FILELIST = rvv_coproc.f
LOG      = sim.log
PASS_MSG = SIMULATION PASSED

.PHONY: sim clean

sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
